// File: axil_pkg.sv
package axil_pkg;

	////////////////////////////////////////////////////////////////////////////
	// bus widths
	////////////////////////////////////////////////////////////////////////////

	localparam int axil_addr_w = 15;
	localparam int axil_data_w = 32;
	localparam int axil_strb_w = axil_data_w / 8;

	typedef logic [axil_data_w-1:0] axil_data_t;
	typedef logic [axil_strb_w-1:0] axil_strb_t;
	typedef logic [1:0]             axil_resp_t;

	// response codes
	localparam axil_resp_t resp_okay   = 2'b00;
	localparam axil_resp_t resp_slverr = 2'b10;
	localparam axil_resp_t resp_decerr = 2'b11;

	// one transaction at a time, read before write in idle
	typedef enum logic [2:0] {
		st_idle      = 3'd0,
		st_rd_access = 3'd1,
		st_rd_resp   = 3'd2,
		st_wr_access = 3'd3,
		st_wr_resp   = 3'd4
	} dec_state_t;

endpackage

// File: cfg_pkg.sv
package cfg_pkg;

	////////////////////////////////////////////////////////////////////////////
	// address map
	////////////////////////////////////////////////////////////////////////////

	localparam int region_w = 3;
	localparam int offset_w = 12;

	typedef logic [region_w-1:0] region_t;

	localparam region_t region_cfg   = 3'd0;
	localparam region_t region_mem_a = 3'd1;
	localparam region_t region_mem_b = 3'd2;
	localparam region_t region_link  = 3'd3;

	// host address seen either as one word or as region plus offset
	typedef union packed {
		logic [region_w+offset_w-1:0] raw;
		struct packed {
			region_t             region;
			logic [offset_w-1:0] offset;
		} split;
	} cfg_addr_u;

	// memory targets, word index from offset[9:2]
	localparam int mem_words   = 256;
	localparam int mem_index_w = 8;

	////////////////////////////////////////////////////////////////////////////
	// register block
	////////////////////////////////////////////////////////////////////////////

	localparam int n_targets = 3;
	localparam int en_mem_a  = 0;
	localparam int en_mem_b  = 1;
	localparam int en_link   = 2;

	localparam logic [n_targets-1:0] enable_reset = '1;   // everything on

	localparam logic [offset_w-1:0] off_enable  = 12'h000;   // region 0
	localparam logic [offset_w-1:0] off_prj_sel = 12'h004;
	localparam logic [offset_w-1:0] off_switch  = 12'h000;   // region 3
	localparam logic [offset_w-1:0] off_io_ctl  = 12'h004;

	localparam int prj_sel_w = 5;

endpackage

// File: axil_decoder.sv
`timescale 1ns/10ps

module axil_decoder (
	input  logic                             axi_clk,
	input  logic                             axi_reset_n,
	input  logic                             awvalid,
	input  logic [axil_pkg::axil_addr_w-1:0] awaddr,
	output logic                             awready,
	input  logic                             wvalid,
	input  axil_pkg::axil_data_t             wdata,
	input  axil_pkg::axil_strb_t             wstrb,
	output logic                             wready,
	output logic                             bvalid,
	output axil_pkg::axil_resp_t             bresp,
	input  logic                             bready,
	input  logic                             arvalid,
	input  logic [axil_pkg::axil_addr_w-1:0] araddr,
	output logic                             arready,
	output logic                             rvalid,
	output axil_pkg::axil_data_t             rdata,
	output axil_pkg::axil_resp_t             rresp,
	input  logic                             rready,
	input  logic [cfg_pkg::n_targets-1:0]    target_enable,
	output logic                             req_valid,
	output logic                             req_write,
	output logic [cfg_pkg::offset_w-1:0]     req_offset,
	output axil_pkg::axil_data_t             req_wdata,
	output axil_pkg::axil_strb_t             req_strb,
	output logic                             sel_cfg,
	output logic                             sel_mem_a,
	output logic                             sel_mem_b,
	output logic                             sel_link,
	input  logic                             rsp_valid_cfg,
	input  axil_pkg::axil_data_t             rsp_data_cfg,
	input  logic                             rsp_valid_mem_a,
	input  axil_pkg::axil_data_t             rsp_data_mem_a,
	input  logic                             rsp_valid_mem_b,
	input  axil_pkg::axil_data_t             rsp_data_mem_b,
	input  logic                             rsp_valid_link,
	input  axil_pkg::axil_data_t             rsp_data_link
);
	import axil_pkg::*;
	import cfg_pkg::*;

	dec_state_t state;
	cfg_addr_u  in_addr;
	logic       rd_accept;
	logic       wr_accept;
	logic [3:0] hit_sel;   // {link, mem_b, mem_a, cfg}
	axil_resp_t hit_resp;
	logic       rsp_valid_sel;
	axil_data_t rsp_data_sel;
	axil_data_t rdata_q;
	axil_resp_t resp_q;

	// reads win over writes in idle
	assign rd_accept = (state == st_idle) && arvalid;
	assign wr_accept = (state == st_idle) && !arvalid && awvalid && wvalid;

	assign arready = rd_accept;
	assign awready = wr_accept;
	assign wready  = wr_accept;

	assign rvalid = (state == st_rd_resp);
	assign bvalid = (state == st_wr_resp);
	assign rdata  = rdata_q;
	assign rresp  = resp_q;
	assign bresp  = resp_q;

	always_comb begin
		in_addr.raw = arvalid ? araddr : awaddr;
	end

	////////////////////////////////////////////////////////////////////////////
	// region decode
	////////////////////////////////////////////////////////////////////////////

	always_comb begin
		hit_sel  = '0;
		hit_resp = resp_okay;
		case (in_addr.split.region)
			region_cfg: hit_sel[0] = 1'b1;   // never disabled
			region_mem_a: begin
				if (target_enable[en_mem_a]) hit_sel[1] = 1'b1;
				else hit_resp = resp_slverr;
			end
			region_mem_b: begin
				if (target_enable[en_mem_b]) hit_sel[2] = 1'b1;
				else hit_resp = resp_slverr;
			end
			region_link: begin
				if (target_enable[en_link]) hit_sel[3] = 1'b1;
				else hit_resp = resp_slverr;
			end
			default: hit_resp = resp_decerr;
		endcase
	end

	always_comb begin
		rsp_valid_sel = (sel_cfg & rsp_valid_cfg) | (sel_mem_a & rsp_valid_mem_a) |
			(sel_mem_b & rsp_valid_mem_b) | (sel_link & rsp_valid_link);
		if (sel_mem_a) rsp_data_sel = rsp_data_mem_a;
		else if (sel_mem_b) rsp_data_sel = rsp_data_mem_b;
		else if (sel_link) rsp_data_sel = rsp_data_link;
		else rsp_data_sel = rsp_data_cfg;
	end

	always_ff @(posedge axi_clk or negedge axi_reset_n) begin
		if (!axi_reset_n) begin
			state <= st_idle;
			req_valid <= 1'b0;
			{sel_link, sel_mem_b, sel_mem_a, sel_cfg} <= '0;
			resp_q <= resp_okay;
		end else begin
			req_valid <= 1'b0;   // single cycle pulse
			case (state)
				st_idle: begin
					if (rd_accept || wr_accept) begin
						req_valid <= |hit_sel;
						{sel_link, sel_mem_b, sel_mem_a, sel_cfg} <= hit_sel;
						resp_q <= hit_resp;
						if (|hit_sel) state <= rd_accept ? st_rd_access : st_wr_access;
						else state <= rd_accept ? st_rd_resp : st_wr_resp;   // error, no access
					end
				end
				st_rd_access, st_wr_access: begin
					if (rsp_valid_sel) begin
						{sel_link, sel_mem_b, sel_mem_a, sel_cfg} <= '0;
						state <= (state == st_rd_access) ? st_rd_resp : st_wr_resp;
					end
				end
				st_rd_resp: if (rready) state <= st_idle;
				st_wr_resp: if (bready) state <= st_idle;
				default: state <= st_idle;
			endcase
		end
	end

	// request payload and read data
	always_ff @(posedge axi_clk) begin
		if (rd_accept || wr_accept) begin
			req_write  <= wr_accept;
			req_offset <= in_addr.split.offset;
			req_wdata  <= wdata;
			req_strb   <= wstrb;
			rdata_q    <= '0;   // stays zero on error
		end else if (state == st_rd_access && rsp_valid_sel) begin
			rdata_q <= rsp_data_sel;
		end
	end

	a_one_accept: assert property (@(posedge axi_clk) disable iff (!axi_reset_n)
		!(arready && awready));

	a_rvalid_hold: assert property (@(posedge axi_clk) disable iff (!axi_reset_n)
		rvalid && !rready |=> rvalid && $stable(rdata));

	a_bvalid_hold: assert property (@(posedge axi_clk) disable iff (!axi_reset_n)
		bvalid && !bready |=> bvalid);

endmodule

// File: cfg_regs.sv
`timescale 1ns/10ps

module cfg_regs (
	input  logic                          axi_clk,
	input  logic                          axi_reset_n,
	input  logic                          req_valid,
	input  logic                          sel,
	input  logic                          req_write,
	input  logic [cfg_pkg::offset_w-1:0]  req_offset,
	input  axil_pkg::axil_data_t          req_wdata,
	output logic                          rsp_valid,
	output axil_pkg::axil_data_t          rsp_data,
	output logic [cfg_pkg::n_targets-1:0] target_enable,
	output logic [cfg_pkg::prj_sel_w-1:0] prj_sel
);
	import axil_pkg::*;
	import cfg_pkg::*;

	logic req_hit;

	assign req_hit = req_valid && sel;

	// whole-word writes, strobes not looked at
	always_ff @(posedge axi_clk or negedge axi_reset_n) begin
		if (!axi_reset_n) begin
			rsp_valid <= 1'b0;
			target_enable <= enable_reset;
			prj_sel <= '0;
		end else begin
			rsp_valid <= req_hit;
			if (req_hit && req_write) begin
				case (req_offset)
					off_enable:  target_enable <= req_wdata[n_targets-1:0];
					off_prj_sel: prj_sel <= req_wdata[prj_sel_w-1:0];
					default: ;
				endcase
			end
		end
	end

	always_ff @(posedge axi_clk) begin
		if (req_hit) begin
			case (req_offset)
				off_enable:  rsp_data <= axil_data_t'(target_enable);
				off_prj_sel: rsp_data <= axil_data_t'(prj_sel);
				default:     rsp_data <= '0;
			endcase
		end
	end

endmodule

// File: mem_target.sv
`timescale 1ns/10ps

module mem_target (
	input  logic                         axi_clk,
	input  logic                         axi_reset_n,
	input  logic                         req_valid,
	input  logic                         sel,
	input  logic                         req_write,
	input  logic [cfg_pkg::offset_w-1:0] req_offset,
	input  axil_pkg::axil_data_t         req_wdata,
	input  axil_pkg::axil_strb_t         req_strb,
	output logic                         rsp_valid,
	output axil_pkg::axil_data_t         rsp_data
);
	import axil_pkg::*;
	import cfg_pkg::*;

	axil_data_t             mem [mem_words];
	logic [mem_index_w-1:0] idx;
	logic                   req_hit;

	assign idx     = req_offset[mem_index_w+1:2];   // upper offset bits alias
	assign req_hit = req_valid && sel;

	always_ff @(posedge axi_clk or negedge axi_reset_n) begin
		if (!axi_reset_n) rsp_valid <= 1'b0;
		else rsp_valid <= req_hit;
	end

	////////////////////////////////////////////////////////////////////////////
	// storage
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge axi_clk) begin
		if (req_hit) begin
			if (req_write) begin
				for (int b = 0; b < axil_strb_w; b++) begin
					if (req_strb[b]) mem[idx][b*8 +: 8] <= req_wdata[b*8 +: 8];
				end
			end
			rsp_data <= mem[idx];   // registered read
		end
	end

	a_rsp_after_req: assert property (@(posedge axi_clk) disable iff (!axi_reset_n)
		rsp_valid |-> $past(req_valid && sel));

endmodule

// File: link_target.sv
`timescale 1ns/10ps

module link_target (
	input  logic                         axi_clk,
	input  logic                         axi_reset_n,
	input  logic                         req_valid,
	input  logic                         sel,
	input  logic                         req_write,
	input  logic [cfg_pkg::offset_w-1:0] req_offset,
	input  axil_pkg::axil_data_t         req_wdata,
	input  axil_pkg::axil_strb_t         req_strb,
	output logic                         rsp_valid,
	output axil_pkg::axil_data_t         rsp_data,
	output logic                         rxen_ctl,
	output logic                         txen_ctl
);
	import axil_pkg::*;
	import cfg_pkg::*;

	axil_data_t switch_reg;
	logic       req_hit;

	assign req_hit = req_valid && sel;

	always_ff @(posedge axi_clk or negedge axi_reset_n) begin
		if (!axi_reset_n) begin
			rsp_valid <= 1'b0;
			switch_reg <= '0;
			rxen_ctl <= 1'b0;
			txen_ctl <= 1'b0;
		end else begin
			rsp_valid <= req_hit;
			if (req_hit && req_write) begin
				if (req_offset == off_switch) begin
					for (int b = 0; b < axil_strb_w; b++) begin
						if (req_strb[b]) switch_reg[b*8 +: 8] <= req_wdata[b*8 +: 8];
					end
				end else if (req_offset == off_io_ctl && req_strb[0]) begin
					rxen_ctl <= req_wdata[0];
					txen_ctl <= req_wdata[1];
				end
			end
		end
	end

	always_ff @(posedge axi_clk) begin
		if (req_hit) begin
			case (req_offset)
				off_switch: rsp_data <= switch_reg;
				off_io_ctl: rsp_data <= axil_data_t'({txen_ctl, rxen_ctl});
				default:    rsp_data <= '0;
			endcase
		end
	end

endmodule

// File: cfg_fabric.sv
`timescale 1ns/10ps

module cfg_fabric (
	input  logic                             axi_clk,
	input  logic                             axi_reset_n,
	// host side
	input  logic                             awvalid,
	input  logic [axil_pkg::axil_addr_w-1:0] awaddr,
	input  logic                             wvalid,
	input  axil_pkg::axil_data_t             wdata,
	input  axil_pkg::axil_strb_t             wstrb,
	input  logic                             bready,
	input  logic                             arvalid,
	input  logic [axil_pkg::axil_addr_w-1:0] araddr,
	input  logic                             rready,
	output logic                             awready,
	output logic                             wready,
	output logic                             bvalid,
	output axil_pkg::axil_resp_t             bresp,
	output logic                             arready,
	output logic                             rvalid,
	output axil_pkg::axil_data_t             rdata,
	output axil_pkg::axil_resp_t             rresp,
	// user side
	output logic [cfg_pkg::prj_sel_w-1:0]    prj_sel,
	output logic                             rxen_ctl,
	output logic                             txen_ctl
);
	import axil_pkg::*;
	import cfg_pkg::*;

	logic                 req_valid;
	logic                 req_write;
	logic [offset_w-1:0]  req_offset;
	axil_data_t           req_wdata;
	axil_strb_t           req_strb;
	logic                 sel_cfg, sel_mem_a, sel_mem_b, sel_link;
	logic                 rsp_valid_cfg, rsp_valid_mem_a, rsp_valid_mem_b, rsp_valid_link;
	axil_data_t           rsp_data_cfg, rsp_data_mem_a, rsp_data_mem_b, rsp_data_link;
	logic [n_targets-1:0] target_enable;

	axil_decoder i_decoder (
		.axi_clk(axi_clk), .axi_reset_n(axi_reset_n),
		.awvalid(awvalid), .awaddr(awaddr), .awready(awready),
		.wvalid(wvalid), .wdata(wdata), .wstrb(wstrb), .wready(wready),
		.bvalid(bvalid), .bresp(bresp), .bready(bready),
		.arvalid(arvalid), .araddr(araddr), .arready(arready),
		.rvalid(rvalid), .rdata(rdata), .rresp(rresp), .rready(rready),
		.target_enable(target_enable),
		.req_valid(req_valid), .req_write(req_write), .req_offset(req_offset),
		.req_wdata(req_wdata), .req_strb(req_strb),
		.sel_cfg(sel_cfg), .sel_mem_a(sel_mem_a), .sel_mem_b(sel_mem_b), .sel_link(sel_link),
		.rsp_valid_cfg(rsp_valid_cfg), .rsp_data_cfg(rsp_data_cfg),
		.rsp_valid_mem_a(rsp_valid_mem_a), .rsp_data_mem_a(rsp_data_mem_a),
		.rsp_valid_mem_b(rsp_valid_mem_b), .rsp_data_mem_b(rsp_data_mem_b),
		.rsp_valid_link(rsp_valid_link), .rsp_data_link(rsp_data_link)
	);

	cfg_regs i_regs (
		.axi_clk(axi_clk), .axi_reset_n(axi_reset_n),
		.req_valid(req_valid), .sel(sel_cfg), .req_write(req_write),
		.req_offset(req_offset), .req_wdata(req_wdata),
		.rsp_valid(rsp_valid_cfg), .rsp_data(rsp_data_cfg),
		.target_enable(target_enable), .prj_sel(prj_sel)
	);

	////////////////////////////////////////////////////////////////////////////
	// targets
	////////////////////////////////////////////////////////////////////////////

	mem_target i_mem_a (
		.axi_clk(axi_clk), .axi_reset_n(axi_reset_n),
		.req_valid(req_valid), .sel(sel_mem_a), .req_write(req_write),
		.req_offset(req_offset), .req_wdata(req_wdata), .req_strb(req_strb),
		.rsp_valid(rsp_valid_mem_a), .rsp_data(rsp_data_mem_a)
	);

	mem_target i_mem_b (
		.axi_clk(axi_clk), .axi_reset_n(axi_reset_n),
		.req_valid(req_valid), .sel(sel_mem_b), .req_write(req_write),
		.req_offset(req_offset), .req_wdata(req_wdata), .req_strb(req_strb),
		.rsp_valid(rsp_valid_mem_b), .rsp_data(rsp_data_mem_b)
	);

	link_target i_link (
		.axi_clk(axi_clk), .axi_reset_n(axi_reset_n),
		.req_valid(req_valid), .sel(sel_link), .req_write(req_write),
		.req_offset(req_offset), .req_wdata(req_wdata), .req_strb(req_strb),
		.rsp_valid(rsp_valid_link), .rsp_data(rsp_data_link),
		.rxen_ctl(rxen_ctl), .txen_ctl(txen_ctl)
	);

endmodule

// File: tb_cfg_fabric.sv
`timescale 1ns/10ps

module tb_cfg_fabric;
	import axil_pkg::*;
	import cfg_pkg::*;

	localparam int n_random = 40;

	typedef enum logic [1:0] {op_wr, op_rd, op_io} op_t;

	typedef struct packed {
		op_t                    op;
		logic [axil_addr_w-1:0] addr;
		axil_data_t             wdata;
		axil_strb_t             strb;
		axil_data_t             exp_data;   // op_io packs {tx, rx} at [9:8], prj_sel below
		axil_resp_t             exp_resp;
	} entry_t;

	logic                   axi_clk;
	logic                   axi_reset_n;
	logic                   awvalid, wvalid, bready, arvalid, rready;
	logic [axil_addr_w-1:0] awaddr, araddr;
	axil_data_t             wdata;
	axil_strb_t             wstrb;
	logic                   awready, wready, bvalid, arready, rvalid;
	axil_resp_t             bresp, rresp;
	axil_data_t             rdata;
	logic [prj_sel_w-1:0]   prj_sel;
	logic                   rxen_ctl, txen_ctl;

	entry_t                 table_q[$];
	axil_data_t             model [mem_words];
	bit                     written [mem_words];
	logic [mem_index_w-1:0] written_idx[$];
	logic [31:0]            lcg_state;
	int                     cycles;
	int                     cycle_limit;

	cfg_fabric i_dut (.*);

	initial axi_clk = 1'b0;
	always #4 axi_clk = ~axi_clk;

	always @(posedge axi_clk) begin
		cycles = cycles + 1;
		if (cycle_limit > 0 && cycles >= cycle_limit) begin
			$display("timeout: the tests did not finish within %0d cycles", cycle_limit);
			abort_run();
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// helpers and checks
	////////////////////////////////////////////////////////////////////////////

	function logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	function automatic logic [axil_addr_w-1:0] addr_of(region_t r, logic [offset_w-1:0] off);
		return {r, off};
	endfunction

	function automatic axil_data_t io_word(logic [prj_sel_w-1:0] prj, logic rx, logic tx);
		return {22'd0, tx, rx, 3'd0, prj};
	endfunction

	// byte lanes with a strobe bit take the new data
	function automatic axil_data_t merge_bytes(axil_data_t old_word, axil_data_t new_word,
			axil_strb_t strb);
		axil_data_t result;
		result = old_word;
		for (int b = 0; b < axil_strb_w; b++) begin
			if (strb[b]) result[b*8 +: 8] = new_word[b*8 +: 8];
		end
		return result;
	endfunction

	task automatic abort_run();
		$display("TESTBENCH FAILED");
		$fatal(1, "run stopped at first error");
	endtask

	task automatic check_data(string what, axil_data_t got, axil_data_t exp);
		if (got !== exp) begin
			$display("ERROR at %0t ns: %s data %h, expected %h", $time, what, got, exp);
			abort_run();
		end
	endtask

	task automatic check_resp(string what, axil_resp_t got, axil_resp_t exp);
		if (got !== exp) begin
			$display("ERROR at %0t ns: %s resp %0d, expected %0d", $time, what, got, exp);
			abort_run();
		end
	endtask

	task automatic check_bit(string what, logic [prj_sel_w-1:0] got, logic [prj_sel_w-1:0] exp);
		if (got !== exp) begin
			$display("ERROR at %0t ns: %s is %h, expected %h", $time, what, got, exp);
			abort_run();
		end
	endtask

	task automatic add_entry(op_t op, logic [axil_addr_w-1:0] addr, axil_data_t wdata,
			axil_strb_t strb, axil_data_t exp_data, axil_resp_t exp_resp);
		table_q.push_back(entry_t'{op, addr, wdata, strb, exp_data, exp_resp});
	endtask

	////////////////////////////////////////////////////////////////////////////
	// host side driver
	////////////////////////////////////////////////////////////////////////////

	task automatic axil_write(input logic [axil_addr_w-1:0] addr, input axil_data_t data,
			input axil_strb_t strb, output axil_resp_t resp);
		int stall;
		@(negedge axi_clk);
		awvalid = 1'b1;
		awaddr = addr;
		wvalid = 1'b1;
		wdata = data;
		wstrb = strb;
		#1;
		while (!(awready && wready)) begin
			@(negedge axi_clk);
			#1;
		end
		@(negedge axi_clk);   // transfer took place on the edge before
		awvalid = 1'b0;
		wvalid = 1'b0;
		while (!bvalid) @(negedge axi_clk);
		stall = int'(lcg_next() % 32'd4);
		repeat (stall) @(negedge axi_clk);
		resp = bresp;
		bready = 1'b1;
		@(negedge axi_clk);
		bready = 1'b0;
	endtask

	task automatic axil_read(input logic [axil_addr_w-1:0] addr, output axil_data_t data,
			output axil_resp_t resp);
		int stall;
		@(negedge axi_clk);
		arvalid = 1'b1;
		araddr = addr;
		#1;
		while (!arready) begin
			@(negedge axi_clk);
			#1;
		end
		@(negedge axi_clk);
		arvalid = 1'b0;
		while (!rvalid) @(negedge axi_clk);
		stall = int'(lcg_next() % 32'd4);
		repeat (stall) @(negedge axi_clk);
		data = rdata;
		resp = rresp;
		rready = 1'b1;
		@(negedge axi_clk);
		rready = 1'b0;
	endtask

	task automatic fill_table();
		add_entry(op_io, '0, '0, '0, io_word(5'd0, 1'b0, 1'b0), resp_okay);
		add_entry(op_rd, addr_of(region_cfg, off_enable), '0, '0, 32'h7, resp_okay);
		// same offset in both memories
		add_entry(op_wr, addr_of(region_mem_a, 12'h010), 32'h1111_1111, 4'hf, '0, resp_okay);
		add_entry(op_wr, addr_of(region_mem_b, 12'h010), 32'h2222_2222, 4'hf, '0, resp_okay);
		add_entry(op_rd, addr_of(region_mem_a, 12'h010), '0, '0, 32'h1111_1111, resp_okay);
		add_entry(op_rd, addr_of(region_mem_b, 12'h010), '0, '0, 32'h2222_2222, resp_okay);
		// partial strobes
		add_entry(op_wr, addr_of(region_mem_a, 12'h020), 32'ha5a5_a5a5, 4'hf, '0, resp_okay);
		add_entry(op_wr, addr_of(region_mem_a, 12'h020), 32'h1234_5678, 4'h5, '0, resp_okay);
		add_entry(op_rd, addr_of(region_mem_a, 12'h020), '0, '0, 32'ha534_a578, resp_okay);
		add_entry(op_wr, addr_of(region_link, off_switch), 32'hcafe_f00d, 4'hf, '0, resp_okay);
		add_entry(op_wr, addr_of(region_link, off_switch), 32'h1122_3344, 4'ha, '0, resp_okay);
		add_entry(op_rd, addr_of(region_link, off_switch), '0, '0, 32'h11fe_330d, resp_okay);
		// serial enables, strobe 0 gates the write
		add_entry(op_wr, addr_of(region_link, off_io_ctl), 32'h3, 4'h1, '0, resp_okay);
		add_entry(op_io, '0, '0, '0, io_word(5'd0, 1'b1, 1'b1), resp_okay);
		add_entry(op_rd, addr_of(region_link, off_io_ctl), '0, '0, 32'h3, resp_okay);
		add_entry(op_wr, addr_of(region_link, off_io_ctl), 32'h0, 4'he, '0, resp_okay);
		add_entry(op_io, '0, '0, '0, io_word(5'd0, 1'b1, 1'b1), resp_okay);
		add_entry(op_wr, addr_of(region_link, off_io_ctl), 32'h2, 4'h1, '0, resp_okay);
		add_entry(op_io, '0, '0, '0, io_word(5'd0, 1'b0, 1'b1), resp_okay);
		add_entry(op_rd, addr_of(region_link, off_io_ctl), '0, '0, 32'h2, resp_okay);
		// project select, then mem_b off and on again
		add_entry(op_wr, addr_of(region_cfg, off_prj_sel), 32'h15, 4'hf, '0, resp_okay);
		add_entry(op_io, '0, '0, '0, io_word(5'h15, 1'b0, 1'b1), resp_okay);
		add_entry(op_rd, addr_of(region_cfg, off_prj_sel), '0, '0, 32'h15, resp_okay);
		add_entry(op_wr, addr_of(region_cfg, off_enable), 32'h5, 4'hf, '0, resp_okay);
		add_entry(op_rd, addr_of(region_cfg, off_enable), '0, '0, 32'h5, resp_okay);
		add_entry(op_rd, addr_of(region_mem_b, 12'h010), '0, '0, '0, resp_slverr);
		add_entry(op_wr, addr_of(region_mem_b, 12'h010), 32'hdead_beef, 4'hf, '0, resp_slverr);
		add_entry(op_wr, addr_of(region_cfg, off_enable), 32'h7, 4'hf, '0, resp_okay);
		add_entry(op_rd, addr_of(region_mem_b, 12'h010), '0, '0, 32'h2222_2222, resp_okay);
		// unmapped region
		add_entry(op_wr, addr_of(3'd5, 12'h010), 32'h1234_5678, 4'hf, '0, resp_decerr);
		add_entry(op_rd, addr_of(3'd5, 12'h010), '0, '0, '0, resp_decerr);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// test sequence
	////////////////////////////////////////////////////////////////////////////

	initial begin
		entry_t                 e;
		axil_resp_t             resp;
		axil_data_t             data;
		axil_strb_t             strb;
		logic [31:0]            r;
		logic [mem_index_w-1:0] idx;
		logic [offset_w-1:0]    off;
		int                     k;
		lcg_state = 32'hb99;
		cycles = 0;
		axi_reset_n = 1'b0;
		awvalid = 1'b0;
		awaddr = '0;
		wvalid = 1'b0;
		wdata = '0;
		wstrb = '0;
		bready = 1'b0;
		arvalid = 1'b0;
		araddr = '0;
		rready = 1'b0;
		fill_table();
		cycle_limit = (table_q.size() + n_random) * 20 + 50;
		repeat (5) @(negedge axi_clk);
		axi_reset_n = 1'b1;

		foreach (table_q[i]) begin
			e = table_q[i];
			case (e.op)
				op_wr: begin
					axil_write(e.addr, e.wdata, e.strb, resp);
					check_resp($sformatf("write to %h", e.addr), resp, e.exp_resp);
				end
				op_rd: begin
					axil_read(e.addr, data, resp);
					check_data($sformatf("read of %h", e.addr), data, e.exp_data);
					check_resp($sformatf("read of %h", e.addr), resp, e.exp_resp);
				end
				default: begin
					@(negedge axi_clk);
					check_bit("prj_sel", prj_sel, e.exp_data[prj_sel_w-1:0]);
					check_bit("rxen_ctl", prj_sel_w'(rxen_ctl), prj_sel_w'(e.exp_data[8]));
					check_bit("txen_ctl", prj_sel_w'(txen_ctl), prj_sel_w'(e.exp_data[9]));
				end
			endcase
		end

		// random mem_a traffic, upper offset bits alias
		for (int n = 0; n < n_random; n++) begin
			r = lcg_next();
			idx = r[15:8];
			if (written_idx.size() == 0 || r[19]) begin
				off = {r[17:16], idx, 2'b00};
				data = lcg_next();
				strb = written[idx] ? r[23:20] : 4'hf;   // first write fills the word
				axil_write(addr_of(region_mem_a, off), data, strb, resp);
				check_resp("random write", resp, resp_okay);
				model[idx] = written[idx] ? merge_bytes(model[idx], data, strb) : data;
				if (!written[idx]) written_idx.push_back(idx);
				written[idx] = 1'b1;
			end else begin
				k = int'(r[31:24]) % written_idx.size();
				idx = written_idx[k];
				off = {r[17:16], idx, 2'b00};
				axil_read(addr_of(region_mem_a, off), data, resp);
				check_data($sformatf("random read of word %0d", idx), data, model[idx]);
				check_resp("random read", resp, resp_okay);
			end
		end

		$display("TESTBENCH PASSED");
		$finish;
	end

endmodule

// File: cfg_fabric.f
axil_pkg.sv
cfg_pkg.sv
axil_decoder.sv
cfg_regs.sv
mem_target.sv
link_target.sv
cfg_fabric.sv
tb_cfg_fabric.sv

// File: Makefile
TOP = tb_cfg_fabric
LOG = sim.log

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): $(wildcard *.sv) cfg_fabric.f
	verilator --binary --timing --assert -f cfg_fabric.f --top-module $(TOP)

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "TESTBENCH FAILED" $(LOG); then exit 1; fi
	@grep -q "TESTBENCH PASSED" $(LOG)

lint:
	verilator --lint-only --timing -Wall -f cfg_fabric.f --top-module cfg_fabric

clean:
	rm -rf obj_dir $(LOG)
